//--- source/load_config.svh
`ifndef LOAD_CONFIG_SVH
`define LOAD_CONFIG_SVH

// data path width in bits
`define XLEN 64

// bytes per data array line
`define LINE_BYTES 16

// lines in the data array, 256 bytes in all
`define LINE_COUNT 16

// speculative store queue entries
`define SQ_DEPTH 4

`endif

//--- source/load_pkg.sv
`include "load_config.svh"

package load_pkg;

    typedef logic [`XLEN-1:0] xdata_t;
    typedef logic [63:0] vaddr_t;
    typedef logic [`XLEN/8-1:0] bmask_t;
    typedef logic [`LINE_BYTES*8-1:0] line_t;
    typedef logic [5:0] rob_tag_t;

    // load opcodes, u suffix means zero extension
    typedef enum logic [2:0] {
        op_lb,
        op_lbu,
        op_lh,
        op_lhu,
        op_lw,
        op_lwu,
        op_ld
    } ld_op_t;

    typedef enum logic [1:0] {
        exc_none,
        exc_load_misaligned,
        exc_load_access_fault
    } ld_except_t;

endpackage

//--- source/load_ifs.sv
`timescale 1ns/10ps

// s1 load request, fanned out to the data array and the store queue
interface ld_req_if
    import load_pkg::*;
();
    logic vld;
    vaddr_t addr;
    bmask_t mask;
    ld_op_t op;
    rob_tag_t tag;
    logic misaligned;

    modport src (
        output vld, addr, mask, op, tag, misaligned
    );

    modport dst (
        input vld, addr, mask, op, tag, misaligned
    );
endinterface

// s2 results of the two parallel parts
interface ld_rsp_if
    import load_pkg::*;
();
    // from the data array
    line_t line;
    logic range_fault;
    // from the store queue
    bmask_t match_vec;
    xdata_t fwd_data;

    modport part (
        output line, range_fault, match_vec, fwd_data
    );

    modport merge (
        input line, range_fault, match_vec, fwd_data
    );
endinterface

//--- source/load_addr_gen.sv
`timescale 1ns/10ps

module load_addr_gen
    import load_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     i_vld,
    input  xdata_t   i_src0,
    input  xdata_t   i_src1,
    input  ld_op_t   i_op,
    input  rob_tag_t i_tag,
    ld_req_if.src    req
);

    vaddr_t s0_vaddr;
    bmask_t s0_base_mask;
    logic [2:0] s0_align;
    logic s0_misaligned;

    assign s0_vaddr = i_src0 + i_src1;

    // size decode, base mask plus the low bits that must be zero
    always_comb begin
        case (i_op)
            op_lb, op_lbu: begin
                s0_base_mask = 8'b0000_0001;
                s0_align = 3'b000;
            end
            op_lh, op_lhu: begin
                s0_base_mask = 8'b0000_0011;
                s0_align = 3'b001;
            end
            op_lw, op_lwu: begin
                s0_base_mask = 8'b0000_1111;
                s0_align = 3'b011;
            end
            default: begin
                s0_base_mask = 8'b1111_1111;
                s0_align = 3'b111;
            end
        endcase
    end

    assign s0_misaligned = |(s0_vaddr[2:0] & s0_align);

    always_ff @(posedge clk) begin
        if (rst) begin
            req.vld <= 1'b0;
        end else begin
            req.vld <= i_vld;
        end
        req.addr <= s0_vaddr;
        // byte lanes within the double word
        req.mask <= s0_base_mask << s0_vaddr[2:0];
        req.op <= i_op;
        req.tag <= i_tag;
        req.misaligned <= s0_misaligned;
    end

endmodule

//--- source/line_data_array.sv
`timescale 1ns/10ps
`include "load_config.svh"

module line_data_array
    import load_pkg::*;
(
    input  logic clk,
    input  logic rst,
    // AXI4-Lite write address
    input  logic i_awvalid,
    output logic o_awready,
    input  logic [$clog2(`LINE_COUNT*`LINE_BYTES)-1:0] i_awaddr,
    // AXI4-Lite write data
    input  logic i_wvalid,
    output logic o_wready,
    input  xdata_t i_wdata,
    input  bmask_t i_wstrb,
    // AXI4-Lite write response
    output logic o_bvalid,
    input  logic i_bready,
    output logic [1:0] o_bresp,
    ld_req_if.dst req,
    ld_rsp_if.part rsp
);

    localparam int IDX_W = $clog2(`LINE_COUNT);
    localparam int OFS_W = $clog2(`LINE_BYTES);

    line_t mem [`LINE_COUNT];

    logic wr_rdy_q;
    logic bvalid_q;
    logic wr_go;
    logic [IDX_W-1:0] wr_idx;
    logic wr_half;

    // one cycle ready pulse while both valids wait and no response is open
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_rdy_q <= 1'b0;
        end else begin
            wr_rdy_q <= i_awvalid && i_wvalid && !bvalid_q && !wr_rdy_q;
        end
    end

    assign o_awready = wr_rdy_q;
    assign o_wready = wr_rdy_q;
    assign wr_go = wr_rdy_q && i_awvalid && i_wvalid;

    assign wr_idx = i_awaddr[OFS_W+IDX_W-1:OFS_W];
    assign wr_half = i_awaddr[OFS_W-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid_q <= 1'b0;
        end else if (wr_go) begin
            bvalid_q <= 1'b1;
        end else if (i_bready) begin
            bvalid_q <= 1'b0;
        end
    end

    assign o_bvalid = bvalid_q;
    assign o_bresp = 2'b00;

    // byte enabled update of one half line
    always_ff @(posedge clk) begin
        if (wr_go) begin
            for (int b = 0; b < `XLEN/8; b++) begin
                if (i_wstrb[b]) begin
                    mem[wr_idx][{wr_half, 3'(b)}*8 +: 8] <= i_wdata[b*8 +: 8];
                end
            end
        end
    end

    // s1 line read and range check
    always_ff @(posedge clk) begin
        rsp.line <= mem[req.addr[OFS_W+IDX_W-1:OFS_W]];
        rsp.range_fault <= req.vld && (|req.addr[63:OFS_W+IDX_W]);
    end

    // no new write is taken while a response is still open
    a_no_accept_during_resp: assert property (
        @(posedge clk) disable iff (rst)
        o_bvalid |-> (!o_awready && !o_wready)
    );

endmodule

//--- source/store_fwd_queue.sv
`timescale 1ns/10ps
`include "load_config.svh"

module store_fwd_queue
    import load_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   i_st_vld,
    input  vaddr_t i_st_addr,
    input  xdata_t i_st_data,
    input  bmask_t i_st_mask,
    input  logic   i_flush,
    output logic   o_full,
    ld_req_if.dst  req,
    ld_rsp_if.part rsp
);

    localparam int CNT_W = $clog2(`SQ_DEPTH + 1);
    localparam int PTR_W = $clog2(`SQ_DEPTH);

    // entries fill from index 0, so a higher index is younger
    logic [60:0] ent_dw [`SQ_DEPTH];
    xdata_t ent_data [`SQ_DEPTH];
    bmask_t ent_mask [`SQ_DEPTH];
    logic [CNT_W-1:0] sq_cnt;

    bmask_t hit_vec;
    xdata_t hit_data;

    assign o_full = (sq_cnt == CNT_W'(`SQ_DEPTH));

    always_ff @(posedge clk) begin
        if (rst || i_flush) begin
            sq_cnt <= '0;
        end else if (i_st_vld && !o_full) begin
            sq_cnt <= sq_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_st_vld && !o_full) begin
            ent_dw[sq_cnt[PTR_W-1:0]] <= i_st_addr[63:3];
            ent_data[sq_cnt[PTR_W-1:0]] <= i_st_data;
            ent_mask[sq_cnt[PTR_W-1:0]] <= i_st_mask;
        end
    end

    // oldest first, so younger matches overwrite older ones
    always_comb begin
        hit_vec = '0;
        hit_data = '0;
        for (int i = 0; i < `SQ_DEPTH; i++) begin
            if ((CNT_W'(i) < sq_cnt) && (ent_dw[i] == req.addr[63:3])) begin
                for (int b = 0; b < `XLEN/8; b++) begin
                    if (ent_mask[i][b] && req.mask[b]) begin
                        hit_vec[b] = 1'b1;
                        hit_data[b*8 +: 8] = ent_data[i][b*8 +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        rsp.match_vec <= req.vld ? hit_vec : '0;
        rsp.fwd_data <= hit_data;
    end

    // pushes are dropped when full, the core must not send them
    a_no_push_full: assert property (
        @(posedge clk) disable iff (rst)
        (i_st_vld && !i_flush) |-> !o_full
    );

endmodule

//--- source/load_merge_wb.sv
`timescale 1ns/10ps
`include "load_config.svh"

module load_merge_wb
    import load_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    ld_rsp_if.merge    rsp,
    input  ld_op_t     i_op,
    input  logic [3:0] i_addr_lo,
    input  rob_tag_t   i_tag,
    input  logic       i_misaligned,
    input  logic       i_vld,
    output logic       o_wb_vld,
    output rob_tag_t   o_wb_tag,
    output xdata_t     o_wb_data,
    output ld_except_t o_wb_except
);

    logic s2_vld;
    ld_op_t s2_op;
    logic [3:0] s2_addr_lo;
    rob_tag_t s2_tag;
    logic s2_misaligned;

    xdata_t line_dw;
    xdata_t merged;
    xdata_t shifted;
    xdata_t ext_data;
    ld_except_t s2_except;

    // s1 side info, lined up with the part results
    always_ff @(posedge clk) begin
        if (rst) begin
            s2_vld <= 1'b0;
        end else begin
            s2_vld <= i_vld;
        end
        s2_op <= i_op;
        s2_addr_lo <= i_addr_lo;
        s2_tag <= i_tag;
        s2_misaligned <= i_misaligned;
    end

    assign line_dw = s2_addr_lo[3] ? rsp.line[127:64] : rsp.line[63:0];

    // forwarded bytes win over the line
    always_comb begin
        for (int b = 0; b < `XLEN/8; b++) begin
            merged[b*8 +: 8] = rsp.match_vec[b] ? rsp.fwd_data[b*8 +: 8] : line_dw[b*8 +: 8];
        end
    end

    assign shifted = merged >> {s2_addr_lo[2:0], 3'b000};

    always_comb begin
        case (s2_op)
            op_lb:   ext_data = {{56{shifted[7]}}, shifted[7:0]};
            op_lbu:  ext_data = {56'd0, shifted[7:0]};
            op_lh:   ext_data = {{48{shifted[15]}}, shifted[15:0]};
            op_lhu:  ext_data = {48'd0, shifted[15:0]};
            op_lw:   ext_data = {{32{shifted[31]}}, shifted[31:0]};
            op_lwu:  ext_data = {32'd0, shifted[31:0]};
            default: ext_data = shifted;
        endcase
    end

    // misaligned beats access fault
    assign s2_except = s2_misaligned ? exc_load_misaligned :
                       rsp.range_fault ? exc_load_access_fault : exc_none;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_wb_vld <= 1'b0;
        end else begin
            o_wb_vld <= s2_vld;
        end
        o_wb_tag <= s2_tag;
        o_wb_except <= s2_except;
        o_wb_data <= (s2_except == exc_none) ? ext_data : '0;
    end

endmodule

//--- source/load_unit_top.sv
`timescale 1ns/10ps
`include "load_config.svh"

module load_unit_top
    import load_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    // load issue
    input  logic       i_ld_vld,
    input  xdata_t     i_ld_src0,
    input  xdata_t     i_ld_src1,
    input  ld_op_t     i_ld_op,
    input  rob_tag_t   i_ld_tag,
    // store push and flush
    input  logic       i_st_vld,
    input  vaddr_t     i_st_addr,
    input  xdata_t     i_st_data,
    input  bmask_t     i_st_mask,
    input  logic       i_sq_flush,
    output logic       o_sq_full,
    // AXI4-Lite write slave
    input  logic       s_axi_awvalid,
    output logic       s_axi_awready,
    input  logic [$clog2(`LINE_COUNT*`LINE_BYTES)-1:0] s_axi_awaddr,
    input  logic       s_axi_wvalid,
    output logic       s_axi_wready,
    input  xdata_t     s_axi_wdata,
    input  bmask_t     s_axi_wstrb,
    output logic       s_axi_bvalid,
    input  logic       s_axi_bready,
    output logic [1:0] s_axi_bresp,
    // writeback
    output logic       o_wb_vld,
    output rob_tag_t   o_wb_tag,
    output xdata_t     o_wb_data,
    output ld_except_t o_wb_except
);

    ld_req_if req_if ();
    ld_rsp_if rsp_if ();

    load_addr_gen addr_gen_i (
        .clk    (clk),
        .rst    (rst),
        .i_vld  (i_ld_vld),
        .i_src0 (i_ld_src0),
        .i_src1 (i_ld_src1),
        .i_op   (i_ld_op),
        .i_tag  (i_ld_tag),
        .req    (req_if.src)
    );

    line_data_array data_array_i (
        .clk       (clk),
        .rst       (rst),
        .i_awvalid (s_axi_awvalid),
        .o_awready (s_axi_awready),
        .i_awaddr  (s_axi_awaddr),
        .i_wvalid  (s_axi_wvalid),
        .o_wready  (s_axi_wready),
        .i_wdata   (s_axi_wdata),
        .i_wstrb   (s_axi_wstrb),
        .o_bvalid  (s_axi_bvalid),
        .i_bready  (s_axi_bready),
        .o_bresp   (s_axi_bresp),
        .req       (req_if.dst),
        .rsp       (rsp_if.part)
    );

    store_fwd_queue store_q_i (
        .clk       (clk),
        .rst       (rst),
        .i_st_vld  (i_st_vld),
        .i_st_addr (i_st_addr),
        .i_st_data (i_st_data),
        .i_st_mask (i_st_mask),
        .i_flush   (i_sq_flush),
        .o_full    (o_sq_full),
        .req       (req_if.dst),
        .rsp       (rsp_if.part)
    );

    // s1 side info goes straight from the request bundle
    load_merge_wb merge_wb_i (
        .clk          (clk),
        .rst          (rst),
        .rsp          (rsp_if.merge),
        .i_op         (req_if.op),
        .i_addr_lo    (req_if.addr[3:0]),
        .i_tag        (req_if.tag),
        .i_misaligned (req_if.misaligned),
        .i_vld        (req_if.vld),
        .o_wb_vld     (o_wb_vld),
        .o_wb_tag     (o_wb_tag),
        .o_wb_data    (o_wb_data),
        .o_wb_except  (o_wb_except)
    );

endmodule

//--- testbench/tb_vectors.svh
// columns: kind, src0, src1, opcode, store mask, store data, expected exception
// a store row pushes src0 as its address, a load row uses its row index as tag
localparam int num_rows = 26;

localparam vec_row_t vec_table [num_rows] = '{
    // widths and signedness at aligned offsets
    '{row_load,  64'h10, 64'h3, op_lb,  8'h00, 64'h0, exc_none},
    '{row_load,  64'h10, 64'h3, op_lbu, 8'h00, 64'h0, exc_none},
    '{row_load,  64'h20, 64'h6, op_lh,  8'h00, 64'h0, exc_none},
    '{row_load,  64'h20, 64'h6, op_lhu, 8'h00, 64'h0, exc_none},
    '{row_load,  64'h30, 64'h4, op_lw,  8'h00, 64'h0, exc_none},
    '{row_load,  64'h30, 64'h4, op_lwu, 8'h00, 64'h0, exc_none},
    '{row_load,  64'h38, 64'h0, op_ld,  8'h00, 64'h0, exc_none},
    // misaligned and out of range
    '{row_load,  64'h20, 64'h1, op_lh,  8'h00, 64'h0, exc_load_misaligned},
    '{row_load,  64'h30, 64'h2, op_lw,  8'h00, 64'h0, exc_load_misaligned},
    '{row_load,  64'h40, 64'h4, op_ld,  8'h00, 64'h0, exc_load_misaligned},
    '{row_load,  64'hf8, 64'h8, op_ld,  8'h00, 64'h0, exc_load_access_fault},
    '{row_load,  64'hffff_ffff_ffff_fff0, 64'h0, op_lbu, 8'h00, 64'h0, exc_load_access_fault},
    '{row_load,  64'h100, 64'h3, op_lh, 8'h00, 64'h0, exc_load_misaligned},
    // full, partial and overlapping forwarding
    '{row_store, 64'h60, 64'h0, op_ld,  8'hff, 64'h1122_3344_5566_7788, exc_none},
    '{row_load,  64'h60, 64'h0, op_ld,  8'h00, 64'h0, exc_none},
    '{row_store, 64'h68, 64'h0, op_ld,  8'h0f, 64'h0bad_f00d_cafe_beef, exc_none},
    '{row_load,  64'h68, 64'h0, op_ld,  8'h00, 64'h0, exc_none},
    '{row_store, 64'h68, 64'h0, op_ld,  8'h3c, 64'h9988_7766_5544_3322, exc_none},
    '{row_load,  64'h68, 64'h0, op_ld,  8'h00, 64'h0, exc_none},
    '{row_load,  64'h6c, 64'h0, op_lw,  8'h00, 64'h0, exc_none},
    // flush, partial AXI targets and back to back loads
    '{row_flush, 64'h0,  64'h0, op_ld,  8'h00, 64'h0, exc_none},
    '{row_load,  64'h60, 64'h0, op_ld,  8'h00, 64'h0, exc_none},
    '{row_load,  64'h40, 64'h0, op_ld,  8'h00, 64'h0, exc_none},
    '{row_load,  64'h88, 64'h0, op_ld,  8'h00, 64'h0, exc_none},
    '{row_load,  64'hf0, 64'hf, op_lb,  8'h00, 64'h0, exc_none},
    '{row_load,  64'h0e, 64'h0, op_lhu, 8'h00, 64'h0, exc_none}
};

//--- testbench/tb_load_unit.sv
`timescale 1ns/10ps

module tb_load_unit
    import load_pkg::*;
();

    typedef enum logic [1:0] {
        row_load,
        row_store,
        row_flush
    } row_kind_t;

    typedef struct packed {
        row_kind_t kind;
        vaddr_t src0;
        vaddr_t src1;
        ld_op_t op;
        bmask_t st_mask;
        xdata_t st_data;
        ld_except_t exc;
    } vec_row_t;

`include "tb_vectors.svh"

    localparam int preload_writes = 34;
    localparam int watchdog_cycles = num_rows * 20 + preload_writes * 12 + 20;

    logic clk;
    logic rst;
    logic i_ld_vld;
    xdata_t i_ld_src0;
    xdata_t i_ld_src1;
    ld_op_t i_ld_op;
    rob_tag_t i_ld_tag;
    logic i_st_vld;
    vaddr_t i_st_addr;
    xdata_t i_st_data;
    bmask_t i_st_mask;
    logic i_sq_flush;
    logic o_sq_full;
    logic s_axi_awvalid;
    logic s_axi_awready;
    logic [7:0] s_axi_awaddr;
    logic s_axi_wvalid;
    logic s_axi_wready;
    xdata_t s_axi_wdata;
    bmask_t s_axi_wstrb;
    logic s_axi_bvalid;
    logic s_axi_bready;
    logic [1:0] s_axi_bresp;
    logic o_wb_vld;
    rob_tag_t o_wb_tag;
    xdata_t o_wb_data;
    ld_except_t o_wb_except;

    int cyc = 0;
    int mismatches = 0;
    int other_errors = 0;

    // memory image and pending store model
    logic [7:0] mirror [256];
    vaddr_t sq_addr [$];
    xdata_t sq_data [$];
    bmask_t sq_mask [$];

    // loads in flight, oldest first
    int exp_due [$];
    rob_tag_t exp_tag [$];
    xdata_t exp_data [$];
    ld_except_t exp_exc [$];

    load_unit_top dut_i (.*);

    // edge count moves just before each rising edge
    initial begin
        clk = 1'b0;
        forever begin
            #4;
            cyc = cyc + 1;
            clk = 1'b1;
            #4;
            clk = 1'b0;
        end
    end

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    function automatic int op_bytes(input ld_op_t op);
        case (op)
            op_lb, op_lbu: return 1;
            op_lh, op_lhu: return 2;
            op_lw, op_lwu: return 4;
            default: return 8;
        endcase
    endfunction

    // memory bytes overlaid by the youngest covering store, then extended
    function automatic xdata_t load_expect(input vaddr_t addr, input ld_op_t op);
        int nbytes;
        logic found;
        logic sign;
        vaddr_t ba;
        xdata_t val;
        nbytes = op_bytes(op);
        val = '0;
        for (int i = 0; i < nbytes; i++) begin
            ba = addr + 64'(i);
            val[i*8 +: 8] = mirror[ba[7:0]];
            found = 1'b0;
            for (int s = sq_addr.size() - 1; s >= 0; s--) begin
                if (!found && sq_addr[s][63:3] == ba[63:3] && sq_mask[s][ba[2:0]]) begin
                    val[i*8 +: 8] = sq_data[s][ba[2:0]*8 +: 8];
                    found = 1'b1;
                end
            end
        end
        sign = (op == op_lb || op == op_lh || op == op_lw) && val[nbytes*8-1];
        for (int i = nbytes; i < 8; i++) begin
            val[i*8 +: 8] = {8{sign}};
        end
        return val;
    endfunction

    task automatic axi_write(input logic [7:0] addr, input xdata_t data, input bmask_t strb);
        int resp_cnt;
        resp_cnt = 0;
        @(posedge clk);
        s_axi_awvalid <= 1'b1;
        s_axi_awaddr <= addr;
        s_axi_wvalid <= 1'b1;
        s_axi_wdata <= data;
        s_axi_wstrb <= strb;
        @(negedge clk);
        while (!(s_axi_awready && s_axi_wready)) begin
            @(negedge clk);
        end
        @(posedge clk);
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid <= 1'b0;
        @(negedge clk);
        if (!s_axi_bvalid) begin
            $display("Error at %0t: no write response after the handshake", $time);
            other_errors++;
        end
        @(posedge clk);
        s_axi_bready <= 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (s_axi_bvalid && s_axi_bready) begin
                resp_cnt++;
                compare_value("s_axi_bresp", 64'(s_axi_bresp), 64'd0);
            end
        end
        if (resp_cnt != 1) begin
            $display("Error at %0t: write to %h got %0d responses", $time, addr, resp_cnt);
            other_errors++;
        end
        @(posedge clk);
        s_axi_bready <= 1'b0;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                mirror[{addr[7:3], 3'(b)}] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic apply_row(input int r);
        vec_row_t row;
        row = vec_table[r];
        i_ld_vld <= (row.kind == row_load);
        i_ld_src0 <= row.src0;
        i_ld_src1 <= row.src1;
        i_ld_op <= row.op;
        i_ld_tag <= rob_tag_t'(r);
        i_st_vld <= (row.kind == row_store);
        i_st_addr <= row.src0;
        i_st_data <= row.st_data;
        i_st_mask <= row.st_mask;
        i_sq_flush <= (row.kind == row_flush);
        if (row.kind == row_load) begin
            exp_due.push_back(cyc + 3);
            exp_tag.push_back(rob_tag_t'(r));
            exp_exc.push_back(row.exc);
            if (row.exc == exc_none) begin
                exp_data.push_back(load_expect(row.src0 + row.src1, row.op));
            end else begin
                exp_data.push_back('0);
            end
        end else if (row.kind == row_store) begin
            sq_addr.push_back(row.src0);
            sq_data.push_back(row.st_data);
            sq_mask.push_back(row.st_mask);
        end else begin
            sq_addr.delete();
            sq_data.delete();
            sq_mask.delete();
        end
    endtask

    // writeback check, mid cycle where outputs are stable
    always @(negedge clk) begin
        if (!rst) begin
            if (exp_due.size() > 0 && exp_due[0] == cyc) begin
                if (!o_wb_vld) begin
                    $display("Error at %0t: writeback for tag %0d did not arrive",
                             $time, exp_tag[0]);
                    other_errors++;
                end else begin
                    compare_value("o_wb_tag", 64'(o_wb_tag), 64'(exp_tag[0]));
                    compare_value("o_wb_except", 64'(o_wb_except), 64'(exp_exc[0]));
                    compare_value("o_wb_data", o_wb_data, exp_data[0]);
                end
                void'(exp_due.pop_front());
                void'(exp_tag.pop_front());
                void'(exp_exc.pop_front());
                void'(exp_data.pop_front());
            end else if (o_wb_vld) begin
                $display("Error at %0t: writeback with tag %0d arrived when none was due",
                         $time, o_wb_tag);
                other_errors++;
            end
        end
    end

    initial begin
        #(watchdog_cycles * 8);
        $display("Error at %0t: watchdog expired before the tests finished", $time);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        rst = 1'b1;
        i_ld_vld = 1'b0;
        i_ld_src0 = '0;
        i_ld_src1 = '0;
        i_ld_op = op_lb;
        i_ld_tag = '0;
        i_st_vld = 1'b0;
        i_st_addr = '0;
        i_st_data = '0;
        i_st_mask = '0;
        i_sq_flush = 1'b0;
        s_axi_awvalid = 1'b0;
        s_axi_awaddr = '0;
        s_axi_wvalid = 1'b0;
        s_axi_wdata = '0;
        s_axi_wstrb = '0;
        s_axi_bready = 1'b0;
        void'($urandom(32'h83c188b4));
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare_value("o_wb_vld", 64'(o_wb_vld), 64'd0);
        compare_value("s_axi_bvalid", 64'(s_axi_bvalid), 64'd0);
        compare_value("s_axi_awready", 64'(s_axi_awready), 64'd0);
        compare_value("s_axi_wready", 64'(s_axi_wready), 64'd0);
        compare_value("o_sq_full", 64'(o_sq_full), 64'd0);
        // full preload, then two partial strobes
        // odd bytes get their top bit set so signed loads extend ones
        for (int dw = 0; dw < 32; dw++) begin
            axi_write(8'(dw * 8), {$urandom, $urandom} | 64'h8000_8000_8000_8000, 8'hff);
        end
        axi_write(8'h40, {$urandom, $urandom}, 8'ha5);
        axi_write(8'h88, {$urandom, $urandom}, 8'h3c);
        for (int r = 0; r < num_rows; r++) begin
            @(posedge clk);
            apply_row(r);
        end
        @(posedge clk);
        i_ld_vld <= 1'b0;
        i_st_vld <= 1'b0;
        i_sq_flush <= 1'b0;
        while (exp_due.size() > 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        $display("summary: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches + other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+source
+incdir+testbench
source/load_pkg.sv
source/load_ifs.sv
source/load_addr_gen.sv
source/line_data_array.sv
source/store_fwd_queue.sv
source/load_merge_wb.sv
source/load_unit_top.sv
testbench/tb_load_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the load unit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_load_unit \
    -f compile.f -Mdir build/obj_dir
./build/obj_dir/Vtb_load_unit | tee build/sim.log
if grep -q "\*\* FAIL \*\*" build/sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation finished without failures"
